//--- ctrl_cases.txt
// A, instr, cond{eq,zero,neg}, stall, cycles D to pc_en, alu_fn (f none), rf_wen,
// waddr, wb_sel, pc_sel, mem{valid,rw,len[1:0]}; hex fields
A_24651234_0_0_4_0_1_05_0_0_0 // addiu r5, r3
A_3c07abcd_0_2_4_3_1_07_0_0_0 // lui r7
A_000620c0_0_0_4_3_1_04_0_0_0 // sll r4, r6, 3
A_00084fc3_0_1_4_a_1_09_0_0_0 // sra r9, r8, 31
A_016c5023_0_0_4_1_1_0a_0_0_0 // subu r10
A_01ee6807_0_3_4_a_1_0d_0_0_0 // srav r13
A_8fa30008_0_3_5_f_1_03_1_0_8 // lw r3
A_8044ffff_0_2_5_f_1_04_1_0_9 // lb r4
A_94c50002_0_4_5_f_1_05_1_0_a // lhu r5
A_ac270004_0_3_3_f_0_00_0_0_c // sw r7
A_a5280002_0_2_3_f_0_00_0_0_e // sh r8
A_0c000100_0_0_2_f_1_1f_2_2_0 // jal
A_08000040_0_1_1_f_0_00_0_2_0 // j
A_0080a009_0_0_3_f_1_14_2_3_0 // jalr r20, r4
A_03e00008_0_1_2_f_0_00_0_3_0 // jr r31
A_10220010_4_0_3_1_0_00_0_1_0 // beq, eq
A_14220010_4_0_3_1_0_00_0_0_0 // bne, eq
A_18600008_1_0_3_1_0_00_0_1_0 // blez, neg
A_1c600008_2_0_3_1_0_00_0_0_0 // bgtz, zero
A_04a00004_1_0_3_1_0_00_0_1_0 // bltz, neg
A_04a10004_1_0_3_1_0_00_0_0_0 // bgez, neg
A_00000000_0_1_1_f_0_00_0_0_0 // nop
A_fc000000_0_0_1_f_0_00_0_0_0 // unmatched opcode

//--- flist.f
parc_ctrl_pkg.sv
decode_if.sv
inst_decode.sv
ctrl_seq.sv
ctrl_word.sv
mcparc_core_ctrl.sv
tb_core_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_ctrl
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_core_ctrl.sv
/*
 * Testbench for mcparc_core_ctrl. Every valid line of ctrl_cases.txt is fetched
 * and run as one instruction, with random memory stalls. Run from the project root.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_core_ctrl;
  import parc_ctrl_pkg::*;

  localparam int          MAX_CASES = 64;
  localparam int          TIMEOUT   = 100; // Cycles per wait loop
  localparam logic [31:0] SEED      = 32'h4dc77e57;

  logic                  clk;
  logic                  reset;
  logic                  imemreq_val;
  logic                  imemreq_rdy;
  logic [31:0]           imemresp_msg_data;
  logic                  imemresp_val;
  logic                  dmemreq_msg_rw;
  mem_len_t              dmemreq_msg_len;
  logic                  dmemreq_val;
  logic                  dmemreq_rdy;
  logic                  dmemresp_val;
  logic                  pc_en;
  pc_sel_t               pc_mux_sel;
  logic [REG_ADDR_W-1:0] inst_rs;
  logic [REG_ADDR_W-1:0] inst_rt;
  logic [15:0]           inst_imm;
  logic                  inst_imm_sign;
  logic [25:0]           inst_targ;
  logic [4:0]            inst_shamt;
  logic                  op0_en;
  op0_sel_t              op0_mux_sel;
  logic                  op1_en;
  op1_sel_t              op1_mux_sel;
  logic                  wdata_en;
  alu_fn_t               alu_fn;
  logic                  alu_en;
  dm_sel_t               dmemresp_mux_sel;
  logic                  dmemresp_en;
  wb_sel_t               wb_mux_sel;
  logic                  rf_wen;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic                  branch_cond_eq;
  logic                  branch_cond_zero;
  logic                  branch_cond_neg;

  // Case word: marker, instr, cond, stall, cycles, alu, wen, waddr, wb, pc, mem
  logic [75:0] cases [0:MAX_CASES-1];
  logic [75:0] cur;
  int          n_cases;

  mcparc_core_ctrl dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("Waited more than %0d cycles for %s", TIMEOUT, what);
    $display("Test failed");
    $fatal(1, "timeout");
  endtask

  function automatic int pick_delay(input int max_stall);
    int d;
    d = 0;
    if (max_stall > 0) d = int'($urandom % 32'(max_stall + 1));
    return d;
  endfunction

  // Operand sources by instruction format
  function automatic op0_sel_t expected_op0_sel(input logic [31:0] w);
    op0_sel_t s;
    s = OP0_RDATA;
    if (w[31:26] == OP_LUI) begin
      s = OP0_CONST16;
    end else if (w[31:26] == OP_SPECIAL && w != '0 &&
                 (w[5:0] == FN_SLL || w[5:0] == FN_SRL || w[5:0] == FN_SRA)) begin
      s = OP0_SHAMT;
    end
    return s;
  endfunction

  function automatic op1_sel_t expected_op1_sel(input logic [31:0] w);
    op1_sel_t s;
    case (w[31:26])
      OP_ANDI, OP_ORI, OP_XORI, OP_LUI: s = OP1_ZERO_IMM;
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU,
      OP_SW, OP_SB, OP_SH: s = OP1_SIGN_IMM;
      default: s = OP1_RDATA;
    endcase
    return s;
  endfunction

  function automatic dm_sel_t expected_dm_sel(input logic [31:0] w);
    dm_sel_t s;
    case (w[31:26])
      OP_LB:   s = DM_LB;
      OP_LBU:  s = DM_LBU;
      OP_LH:   s = DM_LH;
      OP_LHU:  s = DM_LHU;
      default: s = DM_LW;
    endcase
    return s;
  endfunction

  // --------------------------------------------------------------------------
  // Fetch: F0 held for imemreq_rdy, F1 held for imemresp_val
  // --------------------------------------------------------------------------
  task automatic fetch_instruction(input logic [31:0] word, input int max_stall);
    int   delay;
    int   n;
    logic done;
    delay = pick_delay(max_stall);
    n     = 0;
    done  = 1'b0;
    while (!done) begin
      if (n > TIMEOUT) abort_timeout("the instruction request handshake");
      imemreq_rdy = 1'b0;
      if (imemreq_val) begin
        if (delay == 0) begin
          imemreq_rdy = 1'b1;
          done        = 1'b1;
        end else begin
          delay--;
        end
      end
      n++;
      @(negedge clk);
    end
    imemreq_rdy = 1'b0;

    delay = pick_delay(max_stall);
    n     = 0;
    while (delay > 0) begin
      if (n > TIMEOUT) abort_timeout("the instruction response");
      check_value("imemreq_val", 32'(imemreq_val), 32'd0);
      imemresp_msg_data = $urandom; // Junk that must not be kept
      delay--;
      n++;
      @(negedge clk);
    end
    check_value("imemreq_val", 32'(imemreq_val), 32'd0);
    imemresp_msg_data = word;
    imemresp_val      = 1'b1;
    @(negedge clk);
    imemresp_val      = 1'b0;
    imemresp_msg_data = $urandom;
    // Now in D, fields come from the loaded word
    check_value("inst_rs", 32'(inst_rs), 32'(word[25:21]));
    check_value("inst_rt", 32'(inst_rt), 32'(word[20:16]));
    check_value("inst_targ", 32'(inst_targ), 32'(word[25:0]));
    check_value("inst_imm", 32'(inst_imm), 32'(word[15:0]));
    check_value("inst_imm_sign", 32'(inst_imm_sign), 32'(word[15]));
    check_value("inst_shamt", 32'(inst_shamt), 32'(word[10:6]));
  endtask

  // --------------------------------------------------------------------------
  // Execute: from D up to the cycle with pc_en
  // --------------------------------------------------------------------------
  task automatic run_execute(input logic [75:0] c, input int max_stall);
    int          idx;
    int          stalls;
    int          wen_n;
    int          req_n;
    int          resp_n;
    int          wdata_n;
    int          req_wait;
    int          resp_wait;
    logic        finished;
    logic        exp_mem;
    logic        exp_load;
    logic [31:0] word;
    idx       = 0;
    stalls    = 0;
    wen_n     = 0;
    req_n     = 0;
    resp_n    = 0;
    wdata_n   = 0;
    req_wait  = pick_delay(max_stall);
    resp_wait = pick_delay(max_stall);
    finished  = 1'b0;
    exp_mem   = c[3];
    exp_load  = c[3] && !c[2];
    word      = c[71:40];
    while (!finished) begin
      if (idx > TIMEOUT) abort_timeout("pc_en");
      dmemreq_rdy  = 1'b0;
      dmemresp_val = 1'b0;
      check_value("imemreq_val", 32'(imemreq_val), 32'd0);
      if (alu_en && c[27:24] != 4'hf) check_value("alu_fn", 32'(alu_fn), 32'(c[27:24]));
      if (op0_en) check_value("op0_mux_sel", 32'(op0_mux_sel), 32'(expected_op0_sel(word)));
      if (op1_en) check_value("op1_mux_sel", 32'(op1_mux_sel), 32'(expected_op1_sel(word)));
      if (wdata_en) begin
        wdata_n++;
        check_value("wdata_en", 32'(wdata_en), 32'(exp_mem));
      end
      if (rf_wen) begin
        wen_n++;
        check_value("rf_waddr", 32'(rf_waddr), 32'(c[19:12]));
        check_value("wb_mux_sel", 32'(wb_mux_sel), 32'(c[11:8]));
      end
      if (!exp_mem || req_n > 0) begin
        check_value("dmemreq_val", 32'(dmemreq_val), 32'd0);
      end else if (dmemreq_val) begin
        check_value("dmemreq_msg_rw", 32'(dmemreq_msg_rw), 32'(c[2]));
        check_value("dmemreq_msg_len", 32'(dmemreq_msg_len), 32'(c[1:0]));
        if (req_wait > 0) begin
          req_wait--;
          stalls++;
        end else begin
          dmemreq_rdy = 1'b1;
          req_n++;
        end
      end
      if (dmemresp_en) begin
        check_value("dmemresp_en", 32'(dmemresp_en), 32'(exp_load));
        check_value("dmemresp_mux_sel", 32'(dmemresp_mux_sel),
                    32'(expected_dm_sel(word)));
        if (resp_wait > 0) begin
          resp_wait--;
          stalls++;
        end else begin
          dmemresp_val = 1'b1;
          resp_n++;
        end
      end
      if (pc_en) begin
        check_value("cycles from D to pc_en", 32'(idx - stalls), 32'(c[31:28]));
        check_value("pc_mux_sel", 32'(pc_mux_sel), 32'(c[7:4]));
        finished = 1'b1;
      end
      @(negedge clk);
      idx++;
    end
    dmemreq_rdy  = 1'b0;
    dmemresp_val = 1'b0;
    check_value("rf_wen cycles", 32'(wen_n), 32'(c[23:20]));
    check_value("wdata_en cycles", 32'(wdata_n), 32'(exp_mem));
    if (exp_mem) check_value("dmem requests", 32'(req_n), 32'd1);
    check_value("dmem responses", 32'(resp_n), 32'(exp_load));
  endtask

  initial begin
    void'($urandom(SEED));
    reset             = 1'b1;
    imemreq_rdy       = 1'b0;
    imemresp_msg_data = '0;
    imemresp_val      = 1'b0;
    dmemreq_rdy       = 1'b0;
    dmemresp_val      = 1'b0;
    branch_cond_eq    = 1'b0;
    branch_cond_zero  = 1'b0;
    branch_cond_neg   = 1'b0;
    for (int i = 0; i < MAX_CASES; i++) begin
      cases[i] = '0;
    end
    $readmemh("ctrl_cases.txt", cases);

    repeat (4) @(negedge clk);
    check_value("imemreq_val", 32'(imemreq_val), 32'd1); // Core sits in F0
    check_value("pc_en", 32'(pc_en), 32'd0);
    check_value("rf_wen", 32'(rf_wen), 32'd0);
    check_value("dmemreq_val", 32'(dmemreq_val), 32'd0);
    reset = 1'b0;

    n_cases = 0;
    while (n_cases < MAX_CASES && cases[n_cases][75:72] == 4'ha) begin
      cur              = cases[n_cases];
      branch_cond_eq   = cur[38];
      branch_cond_zero = cur[37];
      branch_cond_neg  = cur[36];
      fetch_instruction(cur[71:40], int'(cur[35:32]));
      run_execute(cur, int'(cur[35:32]));
      n_cases++;
    end

    if (n_cases == 0) begin
      $display("No valid lines were read from ctrl_cases.txt");
      $display("Test failed");
      $fatal(1, "empty case file");
    end else begin
      $display("%0d instructions checked", n_cases);
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- mcparc_core_ctrl.sv
/*
 * Multicycle PARC control unit top. One memory request in flight at a time.
 * No multiply/divide and no coprocessor 0 support.
 */
`timescale 1ns/1ps
`default_nettype none

module mcparc_core_ctrl (
  input  logic                                 clk,
  input  logic                                 reset,

  // Instruction memory
  output logic                                 imemreq_val,
  input  logic                                 imemreq_rdy,
  input  logic [31:0]                          imemresp_msg_data,
  input  logic                                 imemresp_val,

  // Data memory
  output logic                                 dmemreq_msg_rw,
  output parc_ctrl_pkg::mem_len_t              dmemreq_msg_len,
  output logic                                 dmemreq_val,
  input  logic                                 dmemreq_rdy,
  input  logic                                 dmemresp_val,

  // Control to datapath
  output logic                                 pc_en,
  output parc_ctrl_pkg::pc_sel_t               pc_mux_sel,
  output logic [parc_ctrl_pkg::REG_ADDR_W-1:0] inst_rs,
  output logic [parc_ctrl_pkg::REG_ADDR_W-1:0] inst_rt,
  output logic [15:0]                          inst_imm,
  output logic                                 inst_imm_sign,
  output logic [25:0]                          inst_targ,
  output logic [4:0]                           inst_shamt,
  output logic                                 op0_en,
  output parc_ctrl_pkg::op0_sel_t              op0_mux_sel,
  output logic                                 op1_en,
  output parc_ctrl_pkg::op1_sel_t              op1_mux_sel,
  output logic                                 wdata_en,
  output parc_ctrl_pkg::alu_fn_t               alu_fn,
  output logic                                 alu_en,
  output parc_ctrl_pkg::dm_sel_t               dmemresp_mux_sel,
  output logic                                 dmemresp_en,
  output parc_ctrl_pkg::wb_sel_t               wb_mux_sel,
  output logic                                 rf_wen,
  output logic [parc_ctrl_pkg::REG_ADDR_W-1:0] rf_waddr,

  // Datapath status
  input  logic                                 branch_cond_eq,
  input  logic                                 branch_cond_zero,
  input  logic                                 branch_cond_neg
);
  import parc_ctrl_pkg::*;

  state_t state;

  decode_if dec ();

  inst_decode u_decode (
    .clk, .reset, .state, .imemresp_msg_data,
    .dec              (dec.dec),
    .inst_imm, .inst_imm_sign, .inst_targ, .inst_shamt,
    .dmemreq_msg_rw, .dmemreq_msg_len, .dmemresp_mux_sel
  );

  ctrl_seq u_seq (
    .clk, .reset,
    .dec          (dec.seq),
    .imemreq_rdy, .imemresp_val, .dmemreq_rdy, .dmemresp_val,
    .state
  );

  ctrl_word u_word (
    .state,
    .dec         (dec.word),
    .branch_cond_eq, .branch_cond_zero, .branch_cond_neg,
    .pc_en, .pc_mux_sel, .imemreq_val,
    .op0_en, .op0_mux_sel, .op1_en, .op1_mux_sel, .wdata_en,
    .alu_fn, .alu_en, .dmemreq_val, .dmemresp_en,
    .wb_mux_sel, .rf_wen, .rf_waddr, .inst_rs, .inst_rt
  );

endmodule

`default_nettype wire

//--- ctrl_word.sv
/*
 * Per-state control word, purely combinational from state and decode.
 * Branch conditions are sampled only in BR2.
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_word (
  input  parc_ctrl_pkg::state_t   state,
  decode_if.word                  dec,
  input  logic                    branch_cond_eq,
  input  logic                    branch_cond_zero,
  input  logic                    branch_cond_neg,
  output logic                    pc_en,
  output parc_ctrl_pkg::pc_sel_t  pc_mux_sel,
  output logic                    imemreq_val,
  output logic                    op0_en,
  output parc_ctrl_pkg::op0_sel_t op0_mux_sel,
  output logic                    op1_en,
  output parc_ctrl_pkg::op1_sel_t op1_mux_sel,
  output logic                    wdata_en,
  output parc_ctrl_pkg::alu_fn_t  alu_fn,
  output logic                    alu_en,
  output logic                    dmemreq_val,
  output logic                    dmemresp_en,
  output parc_ctrl_pkg::wb_sel_t  wb_mux_sel,
  output logic                    rf_wen,
  output logic [parc_ctrl_pkg::REG_ADDR_W-1:0] rf_waddr,
  output logic [parc_ctrl_pkg::REG_ADDR_W-1:0] inst_rs,
  output logic [parc_ctrl_pkg::REG_ADDR_W-1:0] inst_rt
);
  import parc_ctrl_pkg::*;

  logic br_taken;

  // -------------------------------------------------------------------------
  // Branch resolution
  // -------------------------------------------------------------------------
  always_comb begin
    case (dec.br_kind)
      BR_BEQ:  br_taken = branch_cond_eq;
      BR_BLEZ: br_taken = branch_cond_zero || branch_cond_neg;
      BR_BGTZ: br_taken = !branch_cond_zero && !branch_cond_neg;
      BR_BLTZ: br_taken = branch_cond_neg && !branch_cond_zero;
      BR_BGEZ: br_taken = branch_cond_zero || !branch_cond_neg;
      default: br_taken = !branch_cond_eq; // bne
    endcase
  end

  // -------------------------------------------------------------------------
  // Control table
  // -------------------------------------------------------------------------
  always_comb begin
    pc_en       = 1'b0;
    pc_mux_sel  = PC_PLUS4;
    imemreq_val = 1'b0;
    op0_en      = 1'b0;
    op0_mux_sel = OP0_RDATA;
    op1_en      = 1'b0;
    op1_mux_sel = OP1_RDATA;
    wdata_en    = 1'b0;
    alu_fn      = ALU_ADD;
    alu_en      = 1'b0;
    dmemreq_val = 1'b0;
    dmemresp_en = 1'b0;
    wb_mux_sel  = WB_ALU;
    rf_wen      = 1'b0;
    rf_waddr    = dec.rd;

    case (state)
      STATE_F0: imemreq_val = 1'b1;

      // Operand capture
      STATE_IMM0, STATE_SH0, STATE_ALU0, STATE_BR0, STATE_MEM0: begin
        op0_en = 1'b1;
        op1_en = 1'b1;
        if (state == STATE_IMM0) begin
          op0_mux_sel = dec.op0_imm_sel;
          op1_mux_sel = dec.op1_imm_sel;
        end
        if (state == STATE_SH0) op0_mux_sel = OP0_SHAMT;
        if (state == STATE_MEM0) begin
          op1_mux_sel = OP1_SIGN_IMM; // Base plus offset
          wdata_en    = 1'b1;         // Store data
        end
      end
      STATE_JALR0, STATE_JR0: op0_en = 1'b1;

      STATE_IMM1: begin alu_fn = dec.alu_imm_fn; alu_en = 1'b1; end
      STATE_SH1:  begin alu_fn = dec.alu_sh_fn;  alu_en = 1'b1; end
      STATE_ALU1: begin alu_fn = dec.alu_rr_fn;  alu_en = 1'b1; end
      STATE_BR1:  begin alu_fn = ALU_SUB;        alu_en = 1'b1; end

      STATE_MEM1: dmemreq_val = 1'b1; // Address straight from the ALU
      STATE_MEM2: dmemresp_en = 1'b1;

      // Register writeback
      STATE_IMM2: begin rf_wen = 1'b1; rf_waddr = dec.rt; end
      STATE_SH2, STATE_ALU2: rf_wen = 1'b1;
      STATE_MEM3: begin rf_wen = 1'b1; rf_waddr = dec.rt; wb_mux_sel = WB_MEM; end
      STATE_JAL0: begin rf_wen = 1'b1; rf_waddr = REG_LINK; wb_mux_sel = WB_PC4; end
      STATE_JALR1: begin rf_wen = 1'b1; wb_mux_sel = WB_PC4; end

      // PC update ends every path
      STATE_IMM3, STATE_SH3, STATE_ALU3, STATE_MEM4, STATE_NOP: pc_en = 1'b1;
      STATE_JAL1: begin pc_en = 1'b1; pc_mux_sel = PC_JUMP; end
      STATE_JALR2, STATE_JR1: begin pc_en = 1'b1; pc_mux_sel = PC_JUMP_REG; end
      STATE_BR2: begin
        pc_en      = 1'b1;
        pc_mux_sel = br_taken ? PC_BRANCH : PC_PLUS4;
      end
      default: ;
    endcase

    a_no_wen_with_pc: assert (!(rf_wen && pc_en))
      else $error("rf_wen and pc_en both high in state %0d", state);
  end

  assign inst_rs = dec.rs;
  assign inst_rt = dec.rt;

endmodule

`default_nettype wire

//--- ctrl_seq.sv
/*
 * State sequencer. Relies on imemreq_val being raised only in F0 and
 * dmemreq_val only in MEM1, so a ready alone completes those requests.
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_seq (
  input  logic                  clk,
  input  logic                  reset,
  decode_if.seq                 dec,
  input  logic                  imemreq_rdy,
  input  logic                  imemresp_val,
  input  logic                  dmemreq_rdy,
  input  logic                  dmemresp_val,
  output parc_ctrl_pkg::state_t state
);
  import parc_ctrl_pkg::*;

  state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= STATE_F0;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state; // Stalls hold the state
    case (state)
      STATE_F0: if (imemreq_rdy) state_next = STATE_F1;
      STATE_F1: if (imemresp_val) state_next = STATE_D;

      STATE_D: begin
        case (dec.inst_class)
          CLS_IMM:    state_next = STATE_IMM0;
          CLS_SHIFT:  state_next = STATE_SH0;
          CLS_ALU:    state_next = STATE_ALU0;
          CLS_MEM:    state_next = STATE_MEM0;
          CLS_JAL:    state_next = STATE_JAL0;
          CLS_J:      state_next = STATE_JAL1; // Straight to the jump target
          CLS_JALR:   state_next = STATE_JALR0;
          CLS_JR:     state_next = STATE_JR0;
          CLS_BRANCH: state_next = STATE_BR0;
          default:    state_next = STATE_NOP;
        endcase
      end

      STATE_IMM0: state_next = STATE_IMM1;
      STATE_IMM1: state_next = STATE_IMM2;
      STATE_IMM2: state_next = STATE_IMM3;
      STATE_SH0:  state_next = STATE_SH1;
      STATE_SH1:  state_next = STATE_SH2;
      STATE_SH2:  state_next = STATE_SH3;
      STATE_ALU0: state_next = STATE_ALU1;
      STATE_ALU1: state_next = STATE_ALU2;
      STATE_ALU2: state_next = STATE_ALU3;

      // Stores skip the response wait
      STATE_MEM0: state_next = STATE_MEM1;
      STATE_MEM1: if (dmemreq_rdy) state_next = dec.is_load ? STATE_MEM2 : STATE_MEM4;
      STATE_MEM2: if (dmemresp_val) state_next = STATE_MEM3;
      STATE_MEM3: state_next = STATE_MEM4;

      STATE_JAL0:  state_next = STATE_JAL1;
      STATE_JALR0: state_next = STATE_JALR1;
      STATE_JALR1: state_next = STATE_JALR2;
      STATE_JR0:   state_next = STATE_JR1;
      STATE_BR0:   state_next = STATE_BR1;
      STATE_BR1:   state_next = STATE_BR2;

      default: state_next = STATE_F0; // Final state of every path
    endcase
  end

  a_f1_from_f0: assert property (@(posedge clk) disable iff (reset)
    (state != STATE_F1) ##1 (state == STATE_F1) |-> $past(state) == STATE_F0);

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {[STATE_F0:STATE_NOP]});

endmodule

`default_nettype wire

//--- inst_decode.sv
/*
 * Instruction register and decode. The register loads every cycle of F1, so the
 * word present with imemresp_val is the one kept. Unmatched words decode as NOP.
 */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  logic                      clk,
  input  logic                      reset,
  input  parc_ctrl_pkg::state_t     state,
  input  logic [31:0]               imemresp_msg_data,
  decode_if.dec                     dec,
  output logic [15:0]               inst_imm,
  output logic                      inst_imm_sign,
  output logic [25:0]               inst_targ,
  output logic [4:0]                inst_shamt,
  output logic                      dmemreq_msg_rw,
  output parc_ctrl_pkg::mem_len_t   dmemreq_msg_len,
  output parc_ctrl_pkg::dm_sel_t    dmemresp_mux_sel
);
  import parc_ctrl_pkg::*;

  inst_u ir;
  logic  ir_valid; // Set once a fetched word has reached decode

  always_ff @(posedge clk) begin
    if (state == STATE_F1) ir <= imemresp_msg_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ir_valid <= 1'b0;
    end else if (state == STATE_D) begin
      ir_valid <= 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // Instruction class
  // -------------------------------------------------------------------------
  always_comb begin
    dec.inst_class = CLS_NOP;
    case (ir.r_view.opcode)
      OP_SPECIAL: begin
        case (ir.r_view.funct)
          FN_SLL, FN_SRL, FN_SRA:
            if (ir != '0) dec.inst_class = CLS_SHIFT; // All-zero word stays NOP
          FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU, FN_AND,
          FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
            if (ir.r_view.shamt == '0) dec.inst_class = CLS_ALU;
          FN_JR:
            if (ir.r_view.rt == '0 && ir.r_view.rd == '0 && ir.r_view.shamt == '0)
              dec.inst_class = CLS_JR;
          FN_JALR:
            if (ir.r_view.rt == '0 && ir.r_view.shamt == '0) dec.inst_class = CLS_JALR;
          default: ;
        endcase
      end
      OP_REGIMM:        if (ir.i_view.rt[4:1] == '0) dec.inst_class = CLS_BRANCH;
      OP_BLEZ, OP_BGTZ: if (ir.i_view.rt == '0) dec.inst_class = CLS_BRANCH;
      OP_BEQ, OP_BNE:   dec.inst_class = CLS_BRANCH;
      OP_J:             dec.inst_class = CLS_J;
      OP_JAL:           dec.inst_class = CLS_JAL;
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI:
        dec.inst_class = CLS_IMM;
      OP_LUI:           if (ir.i_view.rs == '0) dec.inst_class = CLS_IMM;
      OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_SW, OP_SB, OP_SH:
        dec.inst_class = CLS_MEM;
      default: ;
    endcase
  end

  // ALU functions and operand selects per family
  always_comb begin
    case (ir.i_view.opcode)
      OP_SLTI:  dec.alu_imm_fn = ALU_LT;
      OP_SLTIU: dec.alu_imm_fn = ALU_LTU;
      OP_ANDI:  dec.alu_imm_fn = ALU_AND;
      OP_ORI:   dec.alu_imm_fn = ALU_OR;
      OP_XORI:  dec.alu_imm_fn = ALU_XOR;
      OP_LUI:   dec.alu_imm_fn = ALU_SLL; // imm shifted left by constant 16
      default:  dec.alu_imm_fn = ALU_ADD;
    endcase

    case (ir.r_view.funct[1:0])
      2'b10:   dec.alu_sh_fn = ALU_SRL;
      2'b11:   dec.alu_sh_fn = ALU_SRA;
      default: dec.alu_sh_fn = ALU_SLL;
    endcase

    case (ir.r_view.funct)
      FN_SUBU: dec.alu_rr_fn = ALU_SUB;
      FN_AND:  dec.alu_rr_fn = ALU_AND;
      FN_OR:   dec.alu_rr_fn = ALU_OR;
      FN_XOR:  dec.alu_rr_fn = ALU_XOR;
      FN_NOR:  dec.alu_rr_fn = ALU_NOR;
      FN_SLT:  dec.alu_rr_fn = ALU_LT;
      FN_SLTU: dec.alu_rr_fn = ALU_LTU;
      FN_SLLV: dec.alu_rr_fn = ALU_SLL;
      FN_SRLV: dec.alu_rr_fn = ALU_SRL;
      FN_SRAV: dec.alu_rr_fn = ALU_SRA;
      default: dec.alu_rr_fn = ALU_ADD;
    endcase

    dec.op0_imm_sel = (ir.i_view.opcode == OP_LUI) ? OP0_CONST16 : OP0_RDATA;
    // andi, ori, xori and lui zero-extend
    dec.op1_imm_sel = (ir.i_view.opcode[3:2] == 2'b11) ? OP1_ZERO_IMM : OP1_SIGN_IMM;

    case (ir.i_view.opcode)
      OP_BEQ:    dec.br_kind = BR_BEQ;
      OP_BLEZ:   dec.br_kind = BR_BLEZ;
      OP_BGTZ:   dec.br_kind = BR_BGTZ;
      OP_REGIMM: dec.br_kind = ir.i_view.rt[0] ? BR_BGEZ : BR_BLTZ;
      default:   dec.br_kind = BR_BNE;
    endcase
  end

  // -------------------------------------------------------------------------
  // Memory access kind
  // -------------------------------------------------------------------------
  assign dec.is_load     = !ir.i_view.opcode[3];
  assign dmemreq_msg_rw  = ir.i_view.opcode[3]; // Stores are 1

  always_comb begin
    case (ir.i_view.opcode[1:0])
      2'b00:   dmemreq_msg_len = LEN_BYTE;
      2'b01:   dmemreq_msg_len = LEN_HALF;
      default: dmemreq_msg_len = LEN_WORD;
    endcase
    case (ir.i_view.opcode[2:0])
      3'b000:  dmemresp_mux_sel = DM_LB;
      3'b100:  dmemresp_mux_sel = DM_LBU;
      3'b001:  dmemresp_mux_sel = DM_LH;
      3'b101:  dmemresp_mux_sel = DM_LHU;
      default: dmemresp_mux_sel = DM_LW;
    endcase
  end

  // Fields to the datapath
  assign dec.rs        = ir.r_view.rs;
  assign dec.rt        = ir.r_view.rt;
  assign dec.rd        = ir.r_view.rd;
  assign inst_imm      = ir.i_view.imm16;
  assign inst_imm_sign = ir.i_view.imm16[15];
  assign inst_targ     = {ir.i_view.rs, ir.i_view.rt, ir.i_view.imm16};
  assign inst_shamt    = ir.r_view.shamt;

  a_class_known: assert property (@(posedge clk) disable iff (reset)
    ir_valid |-> !$isunknown(dec.inst_class));

endmodule

`default_nettype wire

//--- decode_if.sv
/*
 * Decoded instruction fields, valid while the instruction register holds.
 */
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
  import parc_ctrl_pkg::*;

  inst_class_t           inst_class;
  logic                  is_load;
  br_kind_t              br_kind;
  alu_fn_t               alu_imm_fn;
  alu_fn_t               alu_sh_fn;
  alu_fn_t               alu_rr_fn;
  op0_sel_t              op0_imm_sel;
  op1_sel_t              op1_imm_sel;
  logic [REG_ADDR_W-1:0] rs;
  logic [REG_ADDR_W-1:0] rt;
  logic [REG_ADDR_W-1:0] rd;

  modport dec (output inst_class, is_load, br_kind, alu_imm_fn, alu_sh_fn, alu_rr_fn,
               output op0_imm_sel, op1_imm_sel, rs, rt, rd);
  modport seq (input inst_class, is_load, br_kind);
  modport word (input inst_class, is_load, br_kind, alu_imm_fn, alu_sh_fn, alu_rr_fn,
                input op0_imm_sel, op1_imm_sel, rs, rt, rd);
endinterface

`default_nettype wire

//--- parc_ctrl_pkg.sv
/*
 * Shared types and encodings for the multicycle PARC control unit.
 * Enum values are the datapath mux and ALU encodings, so do not reorder them.
 */
`default_nettype none

package parc_ctrl_pkg;

  localparam int unsigned REG_ADDR_W = 5;
  localparam logic [REG_ADDR_W-1:0] REG_LINK = 5'd31; // JAL link register

  typedef enum logic [5:0] {
    STATE_F0, STATE_F1, STATE_D,
    STATE_IMM0, STATE_IMM1, STATE_IMM2, STATE_IMM3,
    STATE_SH0, STATE_SH1, STATE_SH2, STATE_SH3,
    STATE_ALU0, STATE_ALU1, STATE_ALU2, STATE_ALU3,
    STATE_MEM0, STATE_MEM1, STATE_MEM2, STATE_MEM3, STATE_MEM4,
    STATE_JAL0, STATE_JAL1,
    STATE_JALR0, STATE_JALR1, STATE_JALR2,
    STATE_JR0, STATE_JR1,
    STATE_BR0, STATE_BR1, STATE_BR2,
    STATE_NOP
  } state_t;

  // Same 32-bit word viewed as R-type or I-type
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_view_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
  } inst_u;

  // First execute state family
  typedef enum logic [3:0] {
    CLS_IMM, CLS_SHIFT, CLS_ALU, CLS_MEM, CLS_JAL,
    CLS_J, CLS_JALR, CLS_JR, CLS_BRANCH, CLS_NOP
  } inst_class_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_OR, ALU_SLL, ALU_LT, ALU_LTU,
    ALU_AND, ALU_XOR, ALU_NOR, ALU_SRL, ALU_SRA
  } alu_fn_t;

  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JUMP_REG} pc_sel_t;
  typedef enum logic [1:0] {OP0_RDATA, OP0_CONST16, OP0_SHAMT} op0_sel_t;
  typedef enum logic [1:0] {OP1_RDATA, OP1_SIGN_IMM, OP1_ZERO_IMM} op1_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;
  typedef enum logic [2:0] {DM_LW, DM_LB, DM_LBU, DM_LH, DM_LHU} dm_sel_t;
  typedef enum logic [1:0] {LEN_WORD, LEN_BYTE, LEN_HALF} mem_len_t;
  typedef enum logic [2:0] {BR_BNE, BR_BEQ, BR_BLEZ, BR_BGTZ, BR_BLTZ, BR_BGEZ} br_kind_t;

  // -------------------------------------------------------------------------
  // Opcodes
  // -------------------------------------------------------------------------
  localparam logic [5:0] OP_SPECIAL = 6'b000000;
  localparam logic [5:0] OP_REGIMM  = 6'b000001; // bltz/bgez, picked by rt
  localparam logic [5:0] OP_J       = 6'b000010;
  localparam logic [5:0] OP_JAL     = 6'b000011;
  localparam logic [5:0] OP_BEQ     = 6'b000100;
  localparam logic [5:0] OP_BNE     = 6'b000101;
  localparam logic [5:0] OP_BLEZ    = 6'b000110;
  localparam logic [5:0] OP_BGTZ    = 6'b000111;
  localparam logic [5:0] OP_ADDIU   = 6'b001001;
  localparam logic [5:0] OP_SLTI    = 6'b001010;
  localparam logic [5:0] OP_SLTIU   = 6'b001011;
  localparam logic [5:0] OP_ANDI    = 6'b001100;
  localparam logic [5:0] OP_ORI     = 6'b001101;
  localparam logic [5:0] OP_XORI    = 6'b001110;
  localparam logic [5:0] OP_LUI     = 6'b001111;
  localparam logic [5:0] OP_LB      = 6'b100000;
  localparam logic [5:0] OP_LH      = 6'b100001;
  localparam logic [5:0] OP_LW      = 6'b100011;
  localparam logic [5:0] OP_LBU     = 6'b100100;
  localparam logic [5:0] OP_LHU     = 6'b100101;
  localparam logic [5:0] OP_SB      = 6'b101000;
  localparam logic [5:0] OP_SH      = 6'b101001;
  localparam logic [5:0] OP_SW      = 6'b101011;

  // SPECIAL function codes
  localparam logic [5:0] FN_SLL  = 6'b000000;
  localparam logic [5:0] FN_SRL  = 6'b000010;
  localparam logic [5:0] FN_SRA  = 6'b000011;
  localparam logic [5:0] FN_SLLV = 6'b000100;
  localparam logic [5:0] FN_SRLV = 6'b000110;
  localparam logic [5:0] FN_SRAV = 6'b000111;
  localparam logic [5:0] FN_JR   = 6'b001000;
  localparam logic [5:0] FN_JALR = 6'b001001;
  localparam logic [5:0] FN_ADDU = 6'b100001;
  localparam logic [5:0] FN_SUBU = 6'b100011;
  localparam logic [5:0] FN_AND  = 6'b100100;
  localparam logic [5:0] FN_OR   = 6'b100101;
  localparam logic [5:0] FN_XOR  = 6'b100110;
  localparam logic [5:0] FN_NOR  = 6'b100111;
  localparam logic [5:0] FN_SLT  = 6'b101010;
  localparam logic [5:0] FN_SLTU = 6'b101011;

endpackage

`default_nettype wire
